// ==== hdl/video_pkg.sv ====
package video_pkg;

    // raster geometry, buffer layout and OSD windows
    typedef struct packed {
        logic [11:0] h_visible;
        logic [11:0] h_total;
        logic [11:0] h_sync_start;
        logic [11:0] h_sync_width;
        logic [11:0] v_visible;
        logic [11:0] v_total;
        logic [11:0] v_sync_start;
        logic [11:0] v_sync_width;
        logic        hsync_polarity;
        logic        vsync_polarity;
        logic [9:0]  line_length;
        logic        line_doubler;
        logic [11:0] osd_bg_x_start;
        logic [11:0] osd_bg_x_end;
        logic [11:0] osd_bg_y_start;
        logic [11:0] osd_bg_y_end;
        logic [11:0] osd_text_x_start;
        logic [11:0] osd_text_x_end;
        logic [11:0] osd_text_y_start;
        logic [11:0] osd_text_y_end;
    } video_config_t;

    // intensity of 256 is unity gain
    typedef struct packed {
        logic       active;
        logic       odd_even;
        logic       thickness;
        logic [8:0] intensity;
    } scanline_t;

    // sync bits here are "pulse active" flags, polarity applied at the output
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic        hsync;
        logic        vsync;
        logic        running;
    } raster_pos_t;

    typedef struct packed {
        logic in_bg;
        logic text_lit;
    } osd_flags_t;

    typedef struct packed {
        logic [23:0] rgb;
        logic        hsync;
        logic        vsync;
        logic        draw_area;
    } video_pixel_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_WARMUP,
        SCAN_RUN
    } scan_state_t;

    localparam int OSD_ALPHA = 64;
    localparam int TEXT_COLUMNS = 40;

endpackage

// ==== hdl/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing import video_pkg::*; #(
    parameter int ADDR_WIDTH = 15
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  video_config_t         config_in,
    input  scanline_t             scanline_in,
    output video_config_t         cfg,
    output scanline_t             scan,
    output raster_pos_t           pos,
    output logic [ADDR_WIDTH-1:0] pixel_addr,
    output logic                  locked
);

    scan_state_t state;
    logic [11:0] x;
    logic [11:0] y;
    logic        line_end;
    logic        frame_end;
    logic        h_active;
    logic        v_active;
    logic [11:0] vs_last;
    logic        visible;
    logic [11:0] row;
    logic [21:0] row_base;

    assign line_end  = x >= cfg.h_total - 12'd1;
    assign frame_end = y >= cfg.v_total - 12'd1;
    assign vs_last   = cfg.v_sync_start + cfg.v_sync_width - 12'd1;

    // 13 bit sums so a window near the top of the range does not wrap
    assign h_active = (x >= cfg.h_sync_start)
                   && ({1'b0, x} < {1'b0, cfg.h_sync_start} + {1'b0, cfg.h_sync_width});
    assign v_active = (y >= cfg.v_sync_start)
                   && ({1'b0, y} < {1'b0, cfg.v_sync_start} + {1'b0, cfg.v_sync_width});

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= SCAN_IDLE;
            x     <= '0;
            y     <= '0;
            cfg   <= '0;
            scan  <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    // settings follow the inputs until start freezes them
                    cfg   <= config_in;
                    scan  <= scanline_in;
                    x     <= '0;
                    y     <= '0;
                    if (start) begin
                        state <= SCAN_WARMUP;
                    end
                end
                SCAN_WARMUP, SCAN_RUN: begin
                    if (line_end) begin
                        x <= '0;
                        y <= frame_end ? 12'd0 : y + 12'd1;
                    end else begin
                        x <= x + 12'd1;
                    end
                    // last sample of the first vsync pulse
                    if (state == SCAN_WARMUP && line_end && y == vs_last) begin
                        state <= SCAN_RUN;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    assign locked = (state == SCAN_RUN);

    assign pos = '{x: x, y: y, hsync: h_active, vsync: v_active, running: locked};

    // line buffer address, doubled rows reuse the same buffer row
    assign visible  = (x < cfg.h_visible) && (y < cfg.v_visible);
    assign row      = cfg.line_doubler ? (y >> 1) : y;
    assign row_base = row * cfg.line_length;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pixel_addr <= '0;
        end else begin
            pixel_addr <= visible ? ADDR_WIDTH'(row_base + 22'(x)) : '0;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        (state != SCAN_IDLE) |-> (x < cfg.h_total));

endmodule

// ==== hdl/font_ram.sv ====
`timescale 1ns/1ps

module font_ram (
    input  logic        clock,
    input  logic        we,
    input  logic [10:0] waddr,
    input  logic [7:0]  wdata,
    input  logic [10:0] raddr,
    output logic [7:0]  rdata
);

    // 128 glyphs of 16 rows, one byte per row
    logic [7:0] mem [0:2047];

    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clock) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hdl/osd_text.sv ====
`timescale 1ns/1ps

module osd_text import video_pkg::*; #(
    parameter int TEXT_ADDR_WIDTH = 10
) (
    input  logic                       clock,
    input  logic                       reset,
    input  video_config_t              cfg,
    input  raster_pos_t                pos,
    input  logic                       osd_enable,
    input  logic [7:0]                 highlight_line,
    input  logic [7:0]                 text_data,
    input  logic [7:0]                 glyph,
    output logic [TEXT_ADDR_WIDTH-1:0] text_addr,
    output logic [10:0]                font_addr_rd,
    output osd_flags_t                 osd
);

    logic            in_bg;
    logic            in_text;
    logic [11:0]     rel_x;
    logic [11:0]     rel_y;
    logic [7:0]      text_row;
    logic [8:0]      text_col;
    logic [15:0]     text_addr_full;
    logic            is_highlight;
    logic [3:0]      row_d1;
    logic [3:0]      row_d2;
    logic [3:0]      bg_pipe;
    logic [3:0]      text_pipe;
    logic [3:0]      hl_pipe;
    logic [3:0][2:0] col_pipe;

    assign in_bg = osd_enable
                && pos.x >= cfg.osd_bg_x_start && pos.x < cfg.osd_bg_x_end
                && pos.y >= cfg.osd_bg_y_start && pos.y < cfg.osd_bg_y_end;

    assign in_text = osd_enable
                  && pos.x >= cfg.osd_text_x_start && pos.x < cfg.osd_text_x_end
                  && pos.y >= cfg.osd_text_y_start && pos.y < cfg.osd_text_y_end;

    assign rel_x    = pos.x - cfg.osd_text_x_start;
    assign rel_y    = pos.y - cfg.osd_text_y_start;
    assign text_row = rel_y[11:4];
    assign text_col = rel_x[11:3];

    assign text_addr_full = text_row * 16'(TEXT_COLUMNS) + 16'(text_col);
    assign is_highlight   = (text_row == highlight_line);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            text_addr    <= '0;
            font_addr_rd <= '0;
            bg_pipe      <= '0;
            text_pipe    <= '0;
            hl_pipe      <= '0;
        end else begin
            text_addr    <= in_text ? TEXT_ADDR_WIDTH'(text_addr_full) : '0;
            // only 7 bit codes, top bit of the text byte is dropped
            font_addr_rd <= {text_data[6:0], row_d2};
            bg_pipe      <= {bg_pipe[2:0], in_bg};
            text_pipe    <= {text_pipe[2:0], in_text};
            hl_pipe      <= {hl_pipe[2:0], is_highlight};
        end
    end

    // glyph row needed at n+2, column at n+4
    always_ff @(posedge clock) begin
        row_d1   <= rel_y[3:0];
        row_d2   <= row_d1;
        col_pipe <= {col_pipe[2:0], rel_x[2:0]};
    end

    assign osd.in_bg    = bg_pipe[3];
    assign osd.text_lit = text_pipe[3] && (glyph[3'd7 - col_pipe[3]] ^ hl_pipe[3]);

    assert property (@(posedge clock) disable iff (reset)
        in_text |-> (text_addr_full < 16'(2 ** TEXT_ADDR_WIDTH)));

endmodule

// ==== hdl/pixel_blend.sv ====
`timescale 1ns/1ps

module pixel_blend import video_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  video_config_t cfg,
    input  scanline_t     scan,
    input  raster_pos_t   pos,
    input  logic [23:0]   pixel_data,
    input  osd_flags_t    osd,
    output video_pixel_t  video
);

    raster_pos_t [3:0] pos_pipe;
    raster_pos_t       cur;
    logic [23:0]       pix_d1;
    logic [23:0]       pix_d2;
    logic              is_scanline;
    logic [16:0]       bg_prod;
    logic [8:0]        alpha;
    logic              draw;
    logic [23:0]       rgb_next;

    function automatic logic [7:0] scale(input logic [7:0] ch, input logic [8:0] a);
        logic [16:0] prod;
        prod = ch * a;
        return prod[15:8];
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pos_pipe <= '0;
        end else begin
            pos_pipe <= {pos_pipe[2:0], pos};
        end
    end

    // ram word lands at n+2, two more stages to meet the glyph
    always_ff @(posedge clock) begin
        pix_d1 <= pixel_data;
        pix_d2 <= pix_d1;
    end

    assign cur = pos_pipe[3];

    assign is_scanline = scan.active && (((cur.y >> scan.thickness) & 12'd1) == 12'(scan.odd_even));
    assign bg_prod     = 17'(OSD_ALPHA) * scan.intensity;

    always_comb begin
        alpha = is_scanline ? scan.intensity : 9'd256;
        if (osd.in_bg) begin
            alpha = is_scanline ? bg_prod[16:8] : 9'(OSD_ALPHA);
        end
    end

    assign draw = (cur.x < cfg.h_visible) && (cur.y < cfg.v_visible);

    always_comb begin
        if (!draw) begin
            rgb_next = '0;
        end else if (osd.text_lit) begin
            rgb_next = '1;
        end else begin
            rgb_next = {scale(pix_d2[23:16], alpha),
                        scale(pix_d2[15:8], alpha),
                        scale(pix_d2[7:0], alpha)};
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video <= '{rgb: '0, hsync: 1'b1, vsync: 1'b1, draw_area: 1'b0};
        end else if (!cur.running) begin
            video <= '{rgb: '0, hsync: ~cfg.hsync_polarity,
                       vsync: ~cfg.vsync_polarity, draw_area: 1'b0};
        end else begin
            video <= '{rgb: rgb_next,
                       hsync: cur.hsync ? cfg.hsync_polarity : ~cfg.hsync_polarity,
                       vsync: cur.vsync ? cfg.vsync_polarity : ~cfg.vsync_polarity,
                       draw_area: draw};
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        video.draw_area |-> (video.hsync != cfg.hsync_polarity));

endmodule

// ==== hdl/video_scanout.sv ====
`timescale 1ns/1ps

module video_scanout import video_pkg::*; #(
    parameter int ADDR_WIDTH      = 15,
    parameter int TEXT_ADDR_WIDTH = 10
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start,
    input  video_config_t              config_in,
    input  scanline_t                  scanline_in,
    input  logic                       osd_enable,
    input  logic [7:0]                 highlight_line,
    input  logic [23:0]                pixel_data,
    input  logic [7:0]                 text_data,
    input  logic                       font_we,
    input  logic [10:0]                font_addr,
    input  logic [7:0]                 font_wdata,
    output logic [ADDR_WIDTH-1:0]      pixel_addr,
    output logic [TEXT_ADDR_WIDTH-1:0] text_addr,
    output video_pixel_t               video,
    output logic                       locked
);

    video_config_t cfg;
    scanline_t     scan;
    raster_pos_t   pos;
    osd_flags_t    osd;
    logic [10:0]   font_addr_rd;
    logic [7:0]    glyph;

    raster_timing #(.ADDR_WIDTH(ADDR_WIDTH)) u_raster_timing (
        .clock(clock), .reset(reset), .start(start),
        .config_in(config_in), .scanline_in(scanline_in),
        .cfg(cfg), .scan(scan), .pos(pos),
        .pixel_addr(pixel_addr), .locked(locked)
    );

    osd_text #(.TEXT_ADDR_WIDTH(TEXT_ADDR_WIDTH)) u_osd_text (
        .clock(clock), .reset(reset), .cfg(cfg), .pos(pos),
        .osd_enable(osd_enable), .highlight_line(highlight_line),
        .text_data(text_data), .glyph(glyph),
        .text_addr(text_addr), .font_addr_rd(font_addr_rd), .osd(osd)
    );

    font_ram u_font_ram (
        .clock(clock), .we(font_we), .waddr(font_addr), .wdata(font_wdata),
        .raddr(font_addr_rd), .rdata(glyph)
    );

    pixel_blend u_pixel_blend (
        .clock(clock), .reset(reset), .cfg(cfg), .scan(scan), .pos(pos),
        .pixel_data(pixel_data), .osd(osd), .video(video)
    );

endmodule

// ==== tests/video_scanout_tb.sv ====
`timescale 1ns/1ps

module video_scanout_tb import video_pkg::*; ();

    localparam int CLOCK_PERIOD = 40;
    localparam int H_TOTAL = 64;
    localparam int H_VISIBLE = 40;
    localparam int H_SYNC_START = 44;
    localparam int H_SYNC_WIDTH = 8;
    localparam int V_TOTAL = 40;
    localparam int V_VISIBLE = 24;
    localparam int V_SYNC_START = 28;
    localparam int V_SYNC_WIDTH = 3;
    localparam int LINE_LENGTH = 40;
    localparam logic H_POL = 1'b0;
    localparam logic V_POL = 1'b1;
    localparam int BG_X0 = 4;
    localparam int BG_X1 = 36;
    localparam int BG_Y0 = 2;
    localparam int BG_Y1 = 23;
    localparam int TEXT_X0 = 8;
    localparam int TEXT_X1 = 32;
    localparam int TEXT_Y0 = 4;
    localparam int TEXT_Y1 = 24;
    localparam int CHECK_FRAMES = 2;
    localparam int PHASES = 3;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int LOCK_CYCLES = (V_SYNC_START + V_SYNC_WIDTH) * H_TOTAL;
    // pixel_addr and text_addr run four samples ahead of video
    localparam int ADDR_LEAD = 4;
    // warm-up frame, partial frame at lock and the checked frames
    localparam int WATCHDOG_CYCLES = PHASES * (CHECK_FRAMES + 2) * FRAME_CYCLES + 2048 + 1000;

    logic          clock;
    logic          reset;
    logic          start;
    video_config_t config_in;
    scanline_t     scanline_in;
    logic          osd_enable;
    logic [7:0]    highlight_line;
    logic [23:0]   pixel_data;
    logic [7:0]    text_data;
    logic          font_we;
    logic [10:0]   font_addr;
    logic [7:0]    font_wdata;
    logic [14:0]   pixel_addr;
    logic [9:0]    text_addr;
    video_pixel_t  video;
    logic          locked;

    logic [15:0] lfsr_state;
    logic [23:0] pix_mem [0:1023];
    logic [7:0]  text_mem [0:1023];
    logic [7:0]  font_mem [0:2047];

    // settings of the running phase for the model
    logic        doubler;
    scanline_t   scan_set;
    logic        osd_on;
    logic [7:0]  hl;

    video_scanout #(.ADDR_WIDTH(15), .TEXT_ADDR_WIDTH(10)) UUT (
        .clock(clock), .reset(reset), .start(start),
        .config_in(config_in), .scanline_in(scanline_in),
        .osd_enable(osd_enable), .highlight_line(highlight_line),
        .pixel_data(pixel_data), .text_data(text_data),
        .font_we(font_we), .font_addr(font_addr), .font_wdata(font_wdata),
        .pixel_addr(pixel_addr), .text_addr(text_addr), .video(video), .locked(locked)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // external RAMs with one cycle read latency
    always @(posedge clock) begin
        pixel_data <= pix_mem[pixel_addr[9:0]];
        text_data  <= text_mem[text_addr];
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic video_config_t make_config(input logic dbl);
        video_config_t c;
        c = '0;
        c.h_visible        = 12'(H_VISIBLE);
        c.h_total          = 12'(H_TOTAL);
        c.h_sync_start     = 12'(H_SYNC_START);
        c.h_sync_width     = 12'(H_SYNC_WIDTH);
        c.v_visible        = 12'(V_VISIBLE);
        c.v_total          = 12'(V_TOTAL);
        c.v_sync_start     = 12'(V_SYNC_START);
        c.v_sync_width     = 12'(V_SYNC_WIDTH);
        c.hsync_polarity   = H_POL;
        c.vsync_polarity   = V_POL;
        c.line_length      = 10'(LINE_LENGTH);
        c.line_doubler     = dbl;
        c.osd_bg_x_start   = 12'(BG_X0);
        c.osd_bg_x_end     = 12'(BG_X1);
        c.osd_bg_y_start   = 12'(BG_Y0);
        c.osd_bg_y_end     = 12'(BG_Y1);
        c.osd_text_x_start = 12'(TEXT_X0);
        c.osd_text_x_end   = 12'(TEXT_X1);
        c.osd_text_y_start = 12'(TEXT_Y0);
        c.osd_text_y_end   = 12'(TEXT_Y1);
        return c;
    endfunction

    // line buffer address, zero outside the visible area
    function automatic int expected_addr(input int x, input int y);
        if (x < H_VISIBLE && y < V_VISIBLE) begin
            return (doubler ? y / 2 : y) * LINE_LENGTH + x;
        end
        return 0;
    endfunction

    function automatic logic in_text_window(input int x, input int y);
        return osd_on && x >= TEXT_X0 && x < TEXT_X1 && y >= TEXT_Y0 && y < TEXT_Y1;
    endfunction

    // text RAM word for a position inside the text window
    function automatic int text_index(input int x, input int y);
        return ((y - TEXT_Y0) / 16) * TEXT_COLUMNS + (x - TEXT_X0) / 8;
    endfunction

    // reference pixel for raster position (x, y)
    function automatic video_pixel_t expected_pixel(input int x, input int y);
        video_pixel_t p;
        int           tx;
        int           ty;
        int           a;
        int           code;
        logic [23:0]  word;
        logic [7:0]   g;
        logic         lit;
        logic         in_bg;
        logic         sl;
        p.hsync = (x >= H_SYNC_START && x < H_SYNC_START + H_SYNC_WIDTH) ? H_POL : ~H_POL;
        p.vsync = (y >= V_SYNC_START && y < V_SYNC_START + V_SYNC_WIDTH) ? V_POL : ~V_POL;
        p.draw_area = (x < H_VISIBLE) && (y < V_VISIBLE);
        p.rgb = '0;
        if (p.draw_area) begin
            in_bg = osd_on && x >= BG_X0 && x < BG_X1 && y >= BG_Y0 && y < BG_Y1;
            lit = 1'b0;
            if (in_text_window(x, y)) begin
                tx = x - TEXT_X0;
                ty = y - TEXT_Y0;
                code = int'(text_mem[10'(text_index(x, y))] & 8'h7f);
                g = font_mem[11'(code * 16 + ty % 16)];
                lit = g[3'(7 - tx % 8)] ^ ((ty / 16) == int'(hl));
            end
            if (lit) begin
                p.rgb = 24'hffffff;
            end else begin
                sl = scan_set.active
                  && (((y >> scan_set.thickness) % 2) == int'(scan_set.odd_even));
                a = sl ? int'(scan_set.intensity) : 256;
                if (in_bg) begin
                    a = sl ? (OSD_ALPHA * int'(scan_set.intensity)) / 256 : OSD_ALPHA;
                end
                word = pix_mem[10'(expected_addr(x, y))];
                for (int i = 0; i < 3; i++) begin
                    p.rgb[8*i +: 8] = 8'((int'(word[8*i +: 8]) * a) / 256);
                end
            end
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_font();
        logic [7:0] d;
        for (int a = 0; a < 2048; a++) begin
            d = 8'(random_bits(8));
            font_mem[11'(a)] = d;
            @(posedge clock);
            font_we    <= 1'b1;
            font_addr  <= 11'(a);
            font_wdata <= d;
        end
        @(posedge clock);
        font_we <= 1'b0;
    endtask

    // follows the output raster from the first hsync after lock
    task automatic check_frames(input string name);
        int x;
        int y;
        int ax;
        int ay;
        int hs_count;
        int vs_lines;
        logic seen_top;
        x = H_SYNC_START;
        y = (V_SYNC_START + V_SYNC_WIDTH) % V_TOTAL;
        hs_count = 0;
        vs_lines = 0;
        seen_top = 1'b0;
        @(negedge clock);
        while (video.hsync !== H_POL) begin
            @(negedge clock);
        end
        repeat (CHECK_FRAMES * FRAME_CYCLES) begin
            check_value($sformatf("%s pixel (%0d,%0d)", name, x, y),
                        64'(expected_pixel(x, y)), 64'(video));
            ax = (x + ADDR_LEAD) % H_TOTAL;
            ay = (x + ADDR_LEAD >= H_TOTAL) ? (y + 1) % V_TOTAL : y;
            check_value($sformatf("%s pixel_addr (%0d,%0d)", name, ax, ay),
                        64'(expected_addr(ax, ay)), 64'(pixel_addr));
            if (in_text_window(ax, ay)) begin
                check_value($sformatf("%s text_addr (%0d,%0d)", name, ax, ay),
                            64'(text_index(ax, ay)), 64'(text_addr));
            end
            if (video.hsync == H_POL) begin
                hs_count++;
            end
            if (x == 0 && video.vsync == V_POL) begin
                vs_lines++;
            end
            if (x == H_TOTAL - 1) begin
                check_value($sformatf("%s hsync width line %0d", name, y),
                            64'(H_SYNC_WIDTH), 64'(hs_count));
                if (y == V_TOTAL - 1) begin
                    if (seen_top) begin
                        check_value($sformatf("%s vsync lines", name),
                                    64'(V_SYNC_WIDTH), 64'(vs_lines));
                    end
                    seen_top = 1'b1;
                    vs_lines = 0;
                end
                hs_count = 0;
                x = 0;
                y = (y + 1) % V_TOTAL;
            end else begin
                x++;
            end
            @(negedge clock);
        end
    endtask

    task automatic run_phase(input string name, input logic dbl, input scanline_t sc,
                             input logic osd, input logic [7:0] hl_line, input logic with_font);
        video_pixel_t idle;
        int count;
        doubler = dbl;
        scan_set = sc;
        osd_on = osd;
        hl = hl_line;
        idle = '{rgb: '0, hsync: ~H_POL, vsync: ~V_POL, draw_area: 1'b0};
        @(posedge clock);
        reset          <= 1'b1;
        start          <= 1'b0;
        config_in      <= make_config(dbl);
        scanline_in    <= sc;
        osd_enable     <= osd;
        highlight_line <= hl_line;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        if (with_font) begin
            load_font();
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_value($sformatf("%s idle locked", name), 64'(1'b0), 64'(locked));
        check_value($sformatf("%s idle video", name), 64'(idle), 64'(video));
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        count = 0;
        @(negedge clock);
        while (!locked) begin
            count++;
            @(negedge clock);
        end
        check_value($sformatf("%s lock cycle", name), 64'(LOCK_CYCLES), 64'(count));
        check_frames(name);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("watchdog expired before all phases completed");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        scanline_t sc_off;
        scanline_t sc_rand;
        clock          = 1'b0;
        reset          = 1'b1;
        start          = 1'b0;
        config_in      = make_config(1'b0);
        scanline_in    = '0;
        osd_enable     = 1'b0;
        highlight_line = '0;
        pixel_data     = '0;
        text_data      = '0;
        font_we        = 1'b0;
        font_addr      = '0;
        font_wdata     = '0;
        lfsr_state     = 16'd58407;
        for (int i = 0; i < 1024; i++) begin
            pix_mem[10'(i)] = 24'(random_bits(24));
            text_mem[10'(i)] = 8'(random_bits(8));
        end
        sc_off = '0;
        run_phase("passthrough", 1'b0, sc_off, 1'b0, 8'd0, 1'b1);

        sc_rand.active    = 1'b1;
        sc_rand.odd_even  = 1'(random_bits(1));
        sc_rand.thickness = 1'(random_bits(1));
        sc_rand.intensity = 9'(random_bits(8));
        run_phase("doubled scanlines", 1'b1, sc_rand, 1'b0, 8'd0, 1'b0);

        sc_rand.odd_even  = 1'(random_bits(1));
        sc_rand.thickness = 1'(random_bits(1));
        sc_rand.intensity = 9'(random_bits(8));
        run_phase("osd", 1'(random_bits(1)), sc_rand, 1'b1, 8'd1, 1'b0);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/video_pkg.sv
hdl/raster_timing.sv
hdl/font_ram.sv
hdl/osd_text.sv
hdl/pixel_blend.sv
hdl/video_scanout.sv
tests/video_scanout_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video scanout testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module video_scanout_tb \
    -f verilog.f -o Vvideo_scanout_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vvideo_scanout_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation log has no pass message"
    exit 1
fi
exit 0
